//--- tb.f
common/mem_sys_pkg.sv
src/init_tracker.sv
ram/imem_ram.sv
ram/dmem_ram.sv
src/dbus_router.sv
debug/debug_apb_master.sv
src/mem_sys_top.sv
test/tb_mem_sys.sv

//--- Makefile
# Verilator build and run for the memory subsystem testbench

TOP             ?= tb_mem_sys
FILELIST        ?= tb.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only --timing --assert
SEED_ARGS       ?= +verilator+seed+39

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulator is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_mem_sys.sv
// ==============================
// Memory subsystem testbench
// Core-side driver, APB debug model
// ==============================

`timescale 1ns/100ps

module tb_mem_sys
  import mem_sys_pkg::*;
();

  localparam int CLK_PERIOD = 4;

  typedef enum logic [1:0] {OP_INIT, OP_FETCH, OP_READ, OP_WRITE} op_t;

  // For writes, exp is the o_tohost value one cycle after the write
  typedef struct packed {
    op_t   op;
    addr_t addr;
    word_t wdata;
    logic  dbg;
    int    waits;
    word_t exp;
  } row_t;

  logic      clk = 1'b0;
  logic      reset_n;
  addr_t     i_init_addr;
  word_t     i_init_data;
  logic      i_init_wen;
  logic      i_resetreq;
  logic      i_imem_rready;
  addr_t     i_imem_addr;
  logic      o_imem_rvalid;
  word_t     o_imem_rdata;
  logic      i_dmem_rready;
  wvalid_t   i_dmem_wvalid;
  addr_t     i_dmem_addr;
  word_t     i_dmem_wdata;
  logic      o_dmem_rvalid;
  logic      o_dmem_wready;
  word_t     o_dmem_rdata;
  logic      i_debug_mode;
  word_t     o_tohost;
  logic      o_core_reset_n;
  logic      o_unavailable;
  apb_addr_t o_apb_paddr;
  logic      o_apb_psel;
  logic      o_apb_penable;
  logic      o_apb_pwrite;
  word_t     o_apb_pwdata;
  logic      i_apb_pready;
  word_t     i_apb_prdata;
  logic      i_apb_pslverr;

  row_t   rows[$];
  logic   table_ready = 1'b0;
  logic   in_burst = 1'b0;
  integer seed;
  int     apb_waits = 0;
  int     wait_left = 0;

  mem_sys_top uut (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_init_addr    (i_init_addr),
    .i_init_data    (i_init_data),
    .i_init_wen     (i_init_wen),
    .i_resetreq     (i_resetreq),
    .i_imem_rready  (i_imem_rready),
    .i_imem_addr    (i_imem_addr),
    .o_imem_rvalid  (o_imem_rvalid),
    .o_imem_rdata   (o_imem_rdata),
    .i_dmem_rready  (i_dmem_rready),
    .i_dmem_wvalid  (i_dmem_wvalid),
    .i_dmem_addr    (i_dmem_addr),
    .i_dmem_wdata   (i_dmem_wdata),
    .o_dmem_rvalid  (o_dmem_rvalid),
    .o_dmem_wready  (o_dmem_wready),
    .o_dmem_rdata   (o_dmem_rdata),
    .i_debug_mode   (i_debug_mode),
    .o_tohost       (o_tohost),
    .o_core_reset_n (o_core_reset_n),
    .o_unavailable  (o_unavailable),
    .o_apb_paddr    (o_apb_paddr),
    .o_apb_psel     (o_apb_psel),
    .o_apb_penable  (o_apb_penable),
    .o_apb_pwrite   (o_apb_pwrite),
    .o_apb_pwdata   (o_apb_pwdata),
    .i_apb_pready   (i_apb_pready),
    .i_apb_prdata   (i_apb_prdata),
    .i_apb_pslverr  (i_apb_pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // Reporting and compares
  // ==============================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_paddr(input string name, input apb_addr_t got, input apb_addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // ==============================
  // Expected values from the address map
  // ==============================
  function automatic logic routes_to_debug(input logic dbg, input addr_t addr);
    return dbg && (addr >= DEBUG_AREA_START) && (addr <= DEBUG_AREA_END);
  endfunction

  // Debug module answers with PADDR xor a fixed tag
  function automatic word_t debug_rdata(input addr_t addr);
    return {19'b0, addr[12:0]} ^ 32'hDB00_0000;
  endfunction

  task automatic add_row(input op_t op, input addr_t addr, input word_t wdata,
                         input logic dbg, input word_t exp);
    row_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.dbg   = dbg;
    r.exp   = exp;
    r.waits = 0;
    if (routes_to_debug(dbg, addr))
      r.waits = $unsigned($random(seed)) % 4;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Init burst with two writes to other banks
    add_row(OP_INIT,  32'h0000_0000, 32'h1111_0001, 1'b0, 32'h0);
    add_row(OP_INIT,  32'h0000_0004, 32'h2222_0002, 1'b0, 32'h0);
    add_row(OP_INIT,  32'h0000_0010, 32'h3333_0003, 1'b0, 32'h0);
    add_row(OP_INIT,  32'h0000_4010, 32'h4444_0004, 1'b0, 32'h0);
    add_row(OP_INIT,  32'h0000_8008, 32'h5555_0005, 1'b0, 32'h0);
    add_row(OP_FETCH, 32'h0000_0000, 32'h0,         1'b0, 32'h1111_0001);
    add_row(OP_FETCH, 32'h0000_0004, 32'h0,         1'b0, 32'h2222_0002);
    add_row(OP_FETCH, 32'h0000_0010, 32'h0,         1'b0, 32'h3333_0003);
    add_row(OP_FETCH, 32'h0000_0008, 32'h0,         1'b0, 32'h0000_0013);
    add_row(OP_FETCH, 32'h0000_4000, 32'h0,         1'b0, 32'h1111_0001);
    // Data RAM traffic
    add_row(OP_READ,  32'h0000_0004, 32'h0,         1'b0, 32'h2222_0002);
    add_row(OP_READ,  32'h0000_0008, 32'h0,         1'b0, 32'h0000_0000);
    add_row(OP_WRITE, 32'h0000_0010, 32'hA5A5_0010, 1'b0, 32'h0);
    add_row(OP_READ,  32'h0000_0010, 32'h0,         1'b0, 32'hA5A5_0010);
    add_row(OP_FETCH, 32'h0000_0010, 32'h0,         1'b0, 32'h3333_0003);
    // Debug area in debug mode
    add_row(OP_READ,  32'h0001_0040, 32'h0,         1'b1, debug_rdata(32'h0001_0040));
    add_row(OP_READ,  32'h0001_0FFC, 32'h0,         1'b1, debug_rdata(32'h0001_0FFC));
    add_row(OP_READ,  32'h0001_0A88, 32'h0,         1'b1, debug_rdata(32'h0001_0A88));
    add_row(OP_READ,  32'h0001_0004, 32'h0,         1'b1, debug_rdata(32'h0001_0004));
    add_row(OP_READ,  32'h0001_0554, 32'h0,         1'b1, debug_rdata(32'h0001_0554));
    add_row(OP_WRITE, 32'h0001_0020, 32'hC0DE_0020, 1'b1, 32'h0);
    add_row(OP_READ,  32'h0000_0020, 32'h0,         1'b0, 32'h0000_0000);
    add_row(OP_READ,  32'h0001_0020, 32'h0,         1'b0, 32'h0000_0000);
    add_row(OP_WRITE, 32'h0001_0020, 32'h7777_0020, 1'b0, 32'h0);
    add_row(OP_READ,  32'h0001_0020, 32'h0,         1'b0, 32'h7777_0020);
    add_row(OP_READ,  32'h0000_0010, 32'h0,         1'b1, 32'hA5A5_0010);
    // tohost capture
    add_row(OP_WRITE, 32'h8000_1000, 32'hFEED_0001, 1'b0, 32'hFEED_0001);
    add_row(OP_WRITE, 32'h8000_1004, 32'h1234_5678, 1'b0, 32'hFEED_0001);
    add_row(OP_WRITE, 32'h0001_0100, 32'hBEEF_0100, 1'b1, 32'hFEED_0001);
    add_row(OP_WRITE, 32'h8000_1000, 32'hFEED_0002, 1'b1, 32'hFEED_0002);
    add_row(OP_READ,  32'h8000_1000, 32'h0,         1'b0, 32'hFEED_0002);
  endtask

  // ==============================
  // Operations
  // ==============================
  task automatic init_write(input row_t r);
    @(negedge clk);
    i_init_wen  = 1'b1;
    i_init_addr = r.addr;
    i_init_data = r.wdata;
    @(negedge clk);
    #1;
    check_bit("o_unavailable", o_unavailable, 1'b1);
    check_bit("o_core_reset_n", o_core_reset_n, 1'b0);
    in_burst = 1'b1;
  endtask

  task automatic end_init_burst();
    @(negedge clk);
    i_init_wen = 1'b0;
    @(negedge clk);
    #1;
    check_bit("o_unavailable", o_unavailable, 1'b0);
    check_bit("o_core_reset_n", o_core_reset_n, 1'b1);
    in_burst = 1'b0;
  endtask

  task automatic fetch(input row_t r);
    @(negedge clk);
    i_imem_rready = 1'b1;
    i_imem_addr   = r.addr;
    #1;
    check_bit("o_imem_rvalid", o_imem_rvalid, 1'b0);
    @(negedge clk);
    i_imem_rready = 1'b0;
    #1;
    check_bit("o_imem_rvalid", o_imem_rvalid, 1'b1);
    check_word("o_imem_rdata", o_imem_rdata, r.exp);
  endtask

  task automatic ram_access(input row_t r);
    @(negedge clk);
    i_debug_mode = r.dbg;
    i_dmem_addr  = r.addr;
    i_dmem_wdata = r.wdata;
    if (r.op == OP_WRITE)
      i_dmem_wvalid = 2'b11;
    else
      i_dmem_rready = 1'b1;
    #1;
    check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
    check_bit("o_dmem_wready", o_dmem_wready, r.op == OP_WRITE);
    @(negedge clk);
    i_dmem_wvalid = 2'b00;
    i_dmem_rready = 1'b0;
    #1;
    check_bit("o_apb_psel", o_apb_psel, 1'b0);
    if (r.op == OP_WRITE)
      check_word("o_tohost", o_tohost, r.exp);
    else
    begin
      check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b1);
      check_word("o_dmem_rdata", o_dmem_rdata, r.exp);
    end
  endtask

  // Request held until the done strobe with APB fields checked every cycle
  task automatic debug_access(input row_t r);
    int   cycles;
    logic done;
    cycles    = 0;
    done      = 1'b0;
    apb_waits = r.waits;
    @(negedge clk);
    i_debug_mode = 1'b1;
    i_dmem_addr  = r.addr;
    i_dmem_wdata = r.wdata;
    if (r.op == OP_WRITE)
      i_dmem_wvalid = 2'b11;
    else
      i_dmem_rready = 1'b1;
    #1;
    check_bit("o_apb_psel", o_apb_psel, 1'b0);
    while (!done)
    begin
      @(negedge clk);
      #1;
      cycles++;
      check_bit("o_apb_psel", o_apb_psel, 1'b1);
      check_bit("o_apb_penable", o_apb_penable, cycles >= 2);
      check_paddr("o_apb_paddr", o_apb_paddr, r.addr[APB_ADDR_W-1:0]);
      check_bit("o_apb_pwrite", o_apb_pwrite, r.op == OP_WRITE);
      if (r.op == OP_WRITE)
      begin
        check_word("o_apb_pwdata", o_apb_pwdata, r.wdata);
        done = o_dmem_wready;
      end
      else
        done = o_dmem_rvalid;
    end
    if (cycles != 2 + r.waits)
      stop_on_error($sformatf("debug access finished after %0d cycles instead of %0d",
                              cycles, 2 + r.waits));
    if (r.op == OP_READ)
      check_word("o_dmem_rdata", o_dmem_rdata, r.exp);
    @(negedge clk);
    i_dmem_wvalid = 2'b00;
    i_dmem_rready = 1'b0;
    #1;
    check_bit("o_apb_psel", o_apb_psel, 1'b0);
    if (r.op == OP_WRITE)
      check_word("o_tohost", o_tohost, r.exp);
  endtask

  // ==============================
  // Debug module model
  // ==============================
  always @(negedge clk)
  begin
    if (o_apb_psel && !o_apb_penable)
    begin
      wait_left    = apb_waits;
      i_apb_pready = 1'b0;
    end
    else if (o_apb_psel && o_apb_penable && (wait_left == 0))
    begin
      i_apb_pready = 1'b1;
      i_apb_prdata = {19'b0, o_apb_paddr} ^ 32'hDB00_0000;
    end
    else
    begin
      if (o_apb_psel && o_apb_penable)
        wait_left--;
      i_apb_pready = 1'b0;
      i_apb_prdata = '0;
    end
  end

  // Watchdog allows 200 cycles per table row
  initial
  begin
    wait (table_ready);
    #(CLK_PERIOD * 200 * (rows.size() + 1));
    stop_on_error("run hung, watchdog expired before the table finished");
  end

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    reset_n       = 1'b0;
    i_init_addr   = '0;
    i_init_data   = '0;
    i_init_wen    = 1'b0;
    i_resetreq    = 1'b0;
    i_imem_rready = 1'b0;
    i_imem_addr   = '0;
    i_dmem_rready = 1'b0;
    i_dmem_wvalid = 2'b00;
    i_dmem_addr   = '0;
    i_dmem_wdata  = '0;
    i_debug_mode  = 1'b0;
    i_apb_pready  = 1'b0;
    i_apb_prdata  = '0;
    i_apb_pslverr = 1'b0;
    seed          = 39;
    build_table();
    table_ready = 1'b1;

    repeat (7) @(negedge clk);
    #1;
    check_bit("o_apb_psel", o_apb_psel, 1'b0);
    check_bit("o_apb_penable", o_apb_penable, 1'b0);
    check_bit("o_imem_rvalid", o_imem_rvalid, 1'b0);
    check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
    check_bit("o_unavailable", o_unavailable, 1'b0);
    check_bit("o_core_reset_n", o_core_reset_n, 1'b0);
    check_word("o_tohost", o_tohost, 32'h0);
    @(negedge clk);
    reset_n = 1'b1;
    #1;
    check_bit("o_core_reset_n", o_core_reset_n, 1'b1);

    // Reset request alone holds the core
    @(negedge clk);
    i_resetreq = 1'b1;
    #1;
    check_bit("o_core_reset_n", o_core_reset_n, 1'b0);
    @(negedge clk);
    i_resetreq = 1'b0;
    #1;
    check_bit("o_core_reset_n", o_core_reset_n, 1'b1);

    foreach (rows[i])
    begin
      if ((rows[i].op != OP_INIT) && in_burst)
        end_init_burst();
      case (rows[i].op)
        OP_INIT:  init_write(rows[i]);
        OP_FETCH: fetch(rows[i]);
        default:
        begin
          if (routes_to_debug(rows[i].dbg, rows[i].addr))
            debug_access(rows[i]);
          else
            ram_access(rows[i]);
        end
      endcase
    end
    if (in_burst)
      end_init_burst();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- src/mem_sys_top.sv
// ==============================
// Memory subsystem top
// RAMs, init control, data routing and debug APB
// ==============================

`timescale 1ns/100ps

module mem_sys_top
  import mem_sys_pkg::*;
#(
  parameter int    IMEM_DEPTH  = 4096,
  parameter int    DMEM_DEPTH  = 4096,
  parameter addr_t TOHOST_ADDR = 32'h8000_1000
) (
  input  logic      clk,
  input  logic      reset_n,
  // Init port
  input  addr_t     i_init_addr,
  input  word_t     i_init_data,
  input  logic      i_init_wen,
  input  logic      i_resetreq,
  // Core fetch bus
  input  logic      i_imem_rready,
  input  addr_t     i_imem_addr,
  output logic      o_imem_rvalid,
  output word_t     o_imem_rdata,
  // Core data bus
  input  logic      i_dmem_rready,
  input  wvalid_t   i_dmem_wvalid,
  input  addr_t     i_dmem_addr,
  input  word_t     i_dmem_wdata,
  output logic      o_dmem_rvalid,
  output logic      o_dmem_wready,
  output word_t     o_dmem_rdata,
  input  logic      i_debug_mode,
  // Status
  output word_t     o_tohost,
  output logic      o_core_reset_n,
  output logic      o_unavailable,
  // APB to debug module
  output apb_addr_t o_apb_paddr,
  output logic      o_apb_psel,
  output logic      o_apb_penable,
  output logic      o_apb_pwrite,
  output word_t     o_apb_pwdata,
  input  logic      i_apb_pready,
  input  word_t     i_apb_prdata,
  // Error response from the debug module is not reported to the core
  input  logic      i_apb_pslverr
);

  logic  init_we;
  logic  ram_we;
  logic  ram_re;
  word_t ram_rdata;
  logic  dbg_start;
  logic  dbg_write;
  logic  dbg_done;
  word_t dbg_rdata;

  init_tracker u_init_tracker (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_init_wen     (i_init_wen),
    .i_init_addr    (i_init_addr),
    .i_resetreq     (i_resetreq),
    .o_init_we      (init_we),
    .o_unavailable  (o_unavailable),
    .o_core_reset_n (o_core_reset_n)
  );

  imem_ram #(
    .DEPTH (IMEM_DEPTH)
  ) u_imem_ram (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_init_we   (init_we),
    .i_init_addr (i_init_addr),
    .i_init_data (i_init_data),
    .i_rready    (i_imem_rready),
    .i_addr      (i_imem_addr),
    .o_rvalid    (o_imem_rvalid),
    .o_rdata     (o_imem_rdata)
  );

  dmem_ram #(
    .DEPTH (DMEM_DEPTH)
  ) u_dmem_ram (
    .clk         (clk),
    .i_we        (ram_we),
    .i_re        (ram_re),
    .i_addr      (i_dmem_addr),
    .i_wdata     (i_dmem_wdata),
    .i_init_we   (init_we),
    .i_init_addr (i_init_addr),
    .i_init_data (i_init_data),
    .o_rdata     (ram_rdata)
  );

  dbus_router #(
    .TOHOST_ADDR (TOHOST_ADDR)
  ) u_dbus_router (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_rready     (i_dmem_rready),
    .i_wvalid     (i_dmem_wvalid),
    .i_addr       (i_dmem_addr),
    .i_wdata      (i_dmem_wdata),
    .i_debug_mode (i_debug_mode),
    .i_ram_rdata  (ram_rdata),
    .i_dbg_done   (dbg_done),
    .i_dbg_rdata  (dbg_rdata),
    .o_rvalid     (o_dmem_rvalid),
    .o_wready     (o_dmem_wready),
    .o_rdata      (o_dmem_rdata),
    .o_ram_we     (ram_we),
    .o_ram_re     (ram_re),
    .o_dbg_start  (dbg_start),
    .o_dbg_write  (dbg_write),
    .o_tohost     (o_tohost)
  );

  debug_apb_master u_debug_apb_master (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_start       (dbg_start),
    .i_write       (dbg_write),
    .i_addr        (i_dmem_addr),
    .i_wdata       (i_dmem_wdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .o_done        (dbg_done),
    .o_rdata       (dbg_rdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata)
  );

endmodule

//--- debug/debug_apb_master.sv
// ==============================
// Debug APB master
// One data access per APB transfer
// ==============================

`timescale 1ns/100ps

module debug_apb_master
  import mem_sys_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  // Request from the data router
  input  logic      i_start,
  input  logic      i_write,
  input  addr_t     i_addr,
  input  word_t     i_wdata,
  output logic      o_done,
  output word_t     o_rdata,
  // APB
  output apb_addr_t o_apb_paddr,
  output logic      o_apb_psel,
  output logic      o_apb_penable,
  output logic      o_apb_pwrite,
  output word_t     o_apb_pwdata,
  input  logic      i_apb_pready,
  input  word_t     i_apb_prdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t state;
  state_t state_nxt;

  // ==============================
  // State machine
  // ==============================
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (i_start)
          state_nxt = ST_SETUP;
      end
      ST_SETUP:
      begin
        state_nxt = ST_ACCESS;
      end
      ST_ACCESS:
      begin
        // Wait states while the slave holds PREADY low
        if (i_apb_pready)
          state_nxt = ST_IDLE;
      end
      default:
      begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // Transfer fields held for the whole transfer
  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && i_start)
    begin
      o_apb_paddr  <= i_addr[APB_ADDR_W-1:0];
      o_apb_pwrite <= i_write;
      o_apb_pwdata <= i_wdata;
    end
  end

  // ==============================
  // Outputs
  // ==============================
  assign o_apb_psel    = (state != ST_IDLE);
  assign o_apb_penable = (state == ST_ACCESS);

  assign o_done  = (state == ST_ACCESS) && i_apb_pready;
  assign o_rdata = i_apb_prdata;

  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!reset_n)
    o_apb_penable |-> o_apb_psel
  );

  // Address fixed from setup through the last wait state
  a_paddr_stable : assert property (
    @(posedge clk) disable iff (!reset_n)
    (o_apb_psel && $past(o_apb_psel)) |-> $stable(o_apb_paddr)
  );

endmodule

//--- src/dbus_router.sv
// ==============================
// Data bus router
// RAM or debug steering, read mux and tohost
// ==============================

`timescale 1ns/100ps

module dbus_router
  import mem_sys_pkg::*;
#(
  parameter addr_t TOHOST_ADDR = 32'h8000_1000
) (
  input  logic    clk,
  input  logic    reset_n,
  // Core data bus
  input  logic    i_rready,
  input  wvalid_t i_wvalid,
  input  addr_t   i_addr,
  input  word_t   i_wdata,
  input  logic    i_debug_mode,
  output logic    o_rvalid,
  output logic    o_wready,
  output word_t   o_rdata,
  // Data RAM
  input  word_t   i_ram_rdata,
  output logic    o_ram_we,
  output logic    o_ram_re,
  // Debug APB master
  input  logic    i_dbg_done,
  input  word_t   i_dbg_rdata,
  output logic    o_dbg_start,
  output logic    o_dbg_write,
  output word_t   o_tohost
);

  logic is_write;
  logic dbg_route;
  logic dbg_pending;
  logic dbg_wr_q;
  logic ram_rvalid_q;

  // ==============================
  // Decode
  // ==============================
  assign is_write  = (i_wvalid != 2'b00);
  assign dbg_route = i_debug_mode &&
                     (i_addr >= DEBUG_AREA_START) && (i_addr <= DEBUG_AREA_END);

  assign o_ram_we = is_write && !dbg_route;
  assign o_ram_re = i_rready && !dbg_route;

  // One start per held debug request
  assign o_dbg_start = dbg_route && (i_rready || is_write) && !dbg_pending;
  assign o_dbg_write = is_write;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      dbg_pending <= 1'b0;
      dbg_wr_q    <= 1'b0;
    end
    else if (o_dbg_start)
    begin
      dbg_pending <= 1'b1;
      dbg_wr_q    <= is_write;
    end
    else if (i_dbg_done)
    begin
      dbg_pending <= 1'b0;
    end
  end

  // ==============================
  // Responses
  // ==============================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ram_rvalid_q <= 1'b0;
    else
      ram_rvalid_q <= o_ram_re;
  end

  assign o_rvalid = ram_rvalid_q || (i_dbg_done && !dbg_wr_q);
  // RAM writes complete at the edge they are presented
  assign o_wready = o_ram_we || (i_dbg_done && dbg_wr_q);
  assign o_rdata  = i_dbg_done ? i_dbg_rdata : i_ram_rdata;

  // Last word written to tohost
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (is_write && (i_addr == TOHOST_ADDR))
      o_tohost <= i_wdata;
  end

  // RAM and debug responses share the read data path
  a_no_dual_response : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(ram_rvalid_q && i_dbg_done)
  );

endmodule

//--- ram/dmem_ram.sv
// ==============================
// Data RAM
// Read/write port plus init write port
// ==============================

`timescale 1ns/100ps

module dmem_ram
  import mem_sys_pkg::*;
#(
  parameter int DEPTH = 4096
) (
  input  logic  clk,
  // Core port
  input  logic  i_we,
  input  logic  i_re,
  input  addr_t i_addr,
  input  word_t i_wdata,
  // Init port
  input  logic  i_init_we,
  input  addr_t i_init_addr,
  input  word_t i_init_data,
  output word_t o_rdata
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] init_idx;
  word_t            mem [DEPTH];

  assign idx      = i_addr[IDX_W+1:2];
  assign init_idx = i_init_addr[IDX_W+1:2];

  // Start from a known zero image
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = '0;
  end

  // Core write lands after init on a shared index
  always_ff @(posedge clk)
  begin
    if (i_init_we)
      mem[init_idx] <= i_init_data;
    if (i_we)
      mem[idx] <= i_wdata;
  end

  // Read before write
  always_ff @(posedge clk)
  begin
    if (i_re)
      o_rdata <= mem[idx];
  end

endmodule

//--- ram/imem_ram.sv
// ==============================
// Instruction RAM
// Init write port, registered fetch read
// ==============================

`timescale 1ns/100ps

module imem_ram
  import mem_sys_pkg::*;
#(
  parameter int DEPTH = 4096
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  i_init_we,
  input  addr_t i_init_addr,
  input  word_t i_init_data,
  input  logic  i_rready,
  input  addr_t i_addr,
  output logic  o_rvalid,
  output word_t o_rdata
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam word_t NOP = 32'h0000_0013;

  word_t mem [DEPTH];

  // Unloaded words execute as addi x0, x0, 0
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = NOP;
  end

  always_ff @(posedge clk)
  begin
    if (i_init_we)
      mem[i_init_addr[IDX_W+1:2]] <= i_init_data;
  end

  always_ff @(posedge clk)
  begin
    if (i_rready)
      o_rdata <= mem[i_addr[IDX_W+1:2]];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_rvalid <= 1'b0;
    else
      o_rvalid <= i_rready;
  end

endmodule

//--- src/init_tracker.sv
// ==============================
// Init tracker
// Load-in-progress flag and core reset
// ==============================

`timescale 1ns/100ps

module init_tracker
  import mem_sys_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  i_init_wen,
  input  addr_t i_init_addr,
  input  logic  i_resetreq,
  output logic  o_init_we,
  output logic  o_unavailable,
  output logic  o_core_reset_n
);

  logic init_wen_q;
  logic busy;

  // Busy from rising edge to falling edge of init_wen
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      init_wen_q <= 1'b0;
      busy       <= 1'b0;
    end
    else
    begin
      init_wen_q <= i_init_wen;
      if (i_init_wen && !init_wen_q)
        busy <= 1'b1;
      else if (!i_init_wen && init_wen_q)
        busy <= 1'b0;
    end
  end

  // Only bank zero is backed by the RAMs
  assign o_init_we = i_init_wen &&
                     (i_init_addr[INIT_BANK_LSB+1:INIT_BANK_LSB] == 2'b00);

  assign o_unavailable  = busy;
  assign o_core_reset_n = reset_n && !i_resetreq && !busy;

  // Hart goes unavailable only after a load has begun
  a_unavail_after_init_edge : assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(o_unavailable) |-> ($past(i_init_wen) && !$past(i_init_wen, 2))
  );

endmodule

//--- common/mem_sys_pkg.sv
// ==============================
// Memory subsystem package
// Shared widths, types and address map
// ==============================

package mem_sys_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int APB_ADDR_W = 13;

  // Data word and core byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Address presented on the debug APB
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;

  // Core write size code where nonzero means a write
  typedef logic [1:0] wvalid_t;

  // ==============================
  // Address map
  // ==============================

  // Inclusive byte range of the debug area
  localparam addr_t DEBUG_AREA_START = 32'h0001_0000;
  localparam addr_t DEBUG_AREA_END   = 32'h0001_0FFF;

  // Lowest of the two init bank bits
  // Both must be zero for an init write to land
  localparam int INIT_BANK_LSB = 14;

endpackage
